// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
RTL_TOP   ?= rv_core_top
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only rtl/rv_pkg.sv rtl/pc_unit.sv rtl/inst_decode.sv \
		rtl/exec_unit.sv rtl/reg_file.sv rtl/rv_core_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t seq_pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t imm,
  input  logic          sel_pc_operand,
  input  logic          sel_zero_operand,
  input  logic          wb_sel_link,
  input  logic          is_jump,
  input  logic          is_jalr,
  output rv_pkg::word_t wb_data,
  output rv_pkg::word_t jump_target,
  output logic          take_jump
);
  import rv_pkg::*;

  word_t operand_a;
  word_t sum;

  // first operand: zero for lui, pc for auipc/jal, rs1 otherwise
  always_comb begin
    if (sel_zero_operand) begin
      operand_a = '0;
    end else if (sel_pc_operand) begin
      operand_a = pc;
    end else begin
      operand_a = rs1_data;
    end
  end

  // the one adder, shared by all supported ops
  assign sum = operand_a + imm;

  // jalr drops bit 0 of the target
  // jal sum is already even
  assign jump_target = {sum[31:1], sum[0] & ~is_jalr};

  // every decoded jump is taken
  assign take_jump = is_jump;

  // link value for jumps, sum for the rest
  assign wb_data = wb_sel_link ? seq_pc : sum;

endmodule

// ==== rtl/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
  input  rv_pkg::word_t     inst,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rd_addr,
  output rv_pkg::word_t     imm,
  output logic              sel_pc_operand,
  output logic              sel_zero_operand,
  output logic              wb_sel_link,
  output logic              is_jump,
  output logic              is_jalr,
  output logic              rd_wen_raw,
  output logic              is_ebreak
);
  import rv_pkg::*;

  // full ebreak encoding
  localparam word_t EBREAK_INST = 32'h0010_0073;
  // funct3 of addi
  localparam logic [2:0] F3_ADDI = 3'b000;

  opcode_t    opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_j;
  word_t      imm_u;

  // fixed instruction fields
  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rd_addr  = inst[11:7];
  assign rs1_addr = inst[19:15];

  // i-type, sign-extended 12 bits
  assign imm_i = {{20{inst[31]}}, inst[31:20]};

  // j-type, scrambled 20-bit offset, bit 0 always zero
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // u-type, already shifted up by 12
  assign imm_u = {inst[31:12], 12'h000};

  // opcode classification
  always_comb begin
    // no-op unless matched below
    imm              = '0;
    sel_pc_operand   = 1'b0;
    sel_zero_operand = 1'b0;
    wb_sel_link      = 1'b0;
    is_jump          = 1'b0;
    is_jalr          = 1'b0;
    rd_wen_raw       = 1'b0;
    is_ebreak        = 1'b0;
    case (opcode)
      OP_IMM: begin
        // only addi, other funct3 stay no-op
        if (funct3 == F3_ADDI) begin
          imm        = imm_i;
          rd_wen_raw = 1'b1;
        end
      end
      OP_LUI: begin
        // 0 + imm_u
        imm              = imm_u;
        sel_zero_operand = 1'b1;
        rd_wen_raw       = 1'b1;
      end
      OP_AUIPC: begin
        // pc + imm_u
        imm            = imm_u;
        sel_pc_operand = 1'b1;
        rd_wen_raw     = 1'b1;
      end
      OP_JAL: begin
        // target pc + imm_j, rd gets pc + 4
        imm            = imm_j;
        sel_pc_operand = 1'b1;
        wb_sel_link    = 1'b1;
        is_jump        = 1'b1;
        rd_wen_raw     = 1'b1;
      end
      OP_JALR: begin
        // target rs1 + imm_i, bit 0 cleared downstream
        imm         = imm_i;
        wb_sel_link = 1'b1;
        is_jump     = 1'b1;
        is_jalr     = 1'b1;
        rd_wen_raw  = 1'b1;
      end
      OP_SYSTEM: begin
        // ecall, csr ops etc fall through as no-ops
        if (inst == EBREAK_INST) begin
          is_ebreak = 1'b1;
        end
      end
      default: begin
        // unsupported, pc still advances by 4
        rd_wen_raw = 1'b0;
      end
    endcase
  end

endmodule

// ==== rtl/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit #(
  parameter rv_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  input  rv_pkg::word_t jump_target,
  input  logic          take_jump,
  input  logic          is_ebreak,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t seq_pc,
  output logic          halted
);
  import rv_pkg::*;

  core_state_t state;
  core_state_t state_next;
  word_t       pc_next;

  // static next pc, also the link value for jumps
  assign seq_pc = pc + INST_BYTES;

  // next pc and next state
  always_comb begin
    state_next = state;
    pc_next    = seq_pc;
    case (state)
      ST_RUN: begin
        if (is_ebreak) begin
          // stop here, pc stays on the ebreak
          state_next = ST_HALTED;
          pc_next    = pc;
        end else if (take_jump) begin
          pc_next = jump_target;
        end
      end
      ST_HALTED: begin
        // frozen until reset
        pc_next = pc;
      end
      default: begin
        state_next = ST_RUN;
      end
    endcase
  end

  // pc register and state register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc    <= RESET_PC;
      state <= ST_RUN;
    end else begin
      pc    <= pc_next;
      state <= state_next;
    end
  end

  assign halted = (state == ST_HALTED);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  logic              wen,
  input  rv_pkg::word_t     wdata,
  output rv_pkg::word_t     rs1_data
);
  import rv_pkg::*;

  // x1..x31, x0 has no storage
  word_t regs [1:31];

  // write on rising edge
  // x0 writes dropped
  always_ff @(posedge clk) begin
    if (wen && (rd_addr != '0)) begin
      regs[rd_addr] <= wdata;
    end
  end

  // combinational read, old value in the write cycle
  always_comb begin
    if (rs1_addr == '0) begin
      // x0 reads zero
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

endmodule

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::word_t     inst,
  output rv_pkg::word_t     pc,
  output logic              halted,
  output logic              rd_wen,
  output rv_pkg::reg_addr_t rd_addr,
  output rv_pkg::word_t     rd_data
);
  import rv_pkg::*;

  // decode outputs
  reg_addr_t rs1_addr;
  word_t     imm;
  logic      sel_pc_operand;
  logic      sel_zero_operand;
  logic      wb_sel_link;
  logic      is_jump;
  logic      is_jalr;
  logic      rd_wen_raw;
  logic      is_ebreak;

  // datapath
  word_t seq_pc;
  word_t rs1_data;
  word_t jump_target;
  logic  take_jump;

  // pc register and halt state
  pc_unit #(
    .RESET_PC(RESET_PC)
  ) pc_unit_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .jump_target(jump_target),
    .take_jump  (take_jump),
    .is_ebreak  (is_ebreak),
    .pc         (pc),
    .seq_pc     (seq_pc),
    .halted     (halted)
  );

  inst_decode inst_decode_inst (
    .inst            (inst),
    .rs1_addr        (rs1_addr),
    .rd_addr         (rd_addr),
    .imm             (imm),
    .sel_pc_operand  (sel_pc_operand),
    .sel_zero_operand(sel_zero_operand),
    .wb_sel_link     (wb_sel_link),
    .is_jump         (is_jump),
    .is_jalr         (is_jalr),
    .rd_wen_raw      (rd_wen_raw),
    .is_ebreak       (is_ebreak)
  );

  exec_unit exec_unit_inst (
    .pc              (pc),
    .seq_pc          (seq_pc),
    .rs1_data        (rs1_data),
    .imm             (imm),
    .sel_pc_operand  (sel_pc_operand),
    .sel_zero_operand(sel_zero_operand),
    .wb_sel_link     (wb_sel_link),
    .is_jump         (is_jump),
    .is_jalr         (is_jalr),
    .wb_data         (rd_data),
    .jump_target     (jump_target),
    .take_jump       (take_jump)
  );

  // no retire while in reset or once halted
  assign rd_wen = rd_wen_raw & ~halted & rst_n;

  // writeback uses the gated enable
  reg_file reg_file_inst (
    .clk     (clk),
    .rs1_addr(rs1_addr),
    .rd_addr (rd_addr),
    .wen     (rd_wen),
    .wdata   (rd_data),
    .rs1_data(rs1_data)
  );

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  // data, address and instruction word
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] reg_addr_t;

  // major opcode field
  typedef logic [6:0] opcode_t;

  // opcodes handled by the core
  // op-imm, only addi (funct3 000) is decoded
  localparam opcode_t OP_IMM    = 7'b001_0011;
  // upper immediate into rd
  localparam opcode_t OP_LUI    = 7'b011_0111;
  // pc plus upper immediate
  localparam opcode_t OP_AUIPC  = 7'b001_0111;
  // pc-relative jump and link
  localparam opcode_t OP_JAL    = 7'b110_1111;
  // register jump and link
  localparam opcode_t OP_JALR   = 7'b110_0111;
  // system space, ebreak only
  localparam opcode_t OP_SYSTEM = 7'b111_0011;

  // sequential pc step, one instruction
  localparam word_t INST_BYTES = 32'h0000_0004;

  // run/halt state of the core
  // halted is sticky until reset
  typedef enum logic [0:0] {
    ST_RUN    = 1'b0,
    ST_HALTED = 1'b1
  } core_state_t;

endpackage

// ==== sim.f ====
rtl/rv_pkg.sv
rtl/pc_unit.sv
rtl/inst_decode.sv
rtl/exec_unit.sv
rtl/reg_file.sv
rtl/rv_core_top.sv
test/core_props.sv
test/core_tb.sv

// ==== test/core_props.sv ====
`timescale 1ns/1ps

module core_props #(
  parameter rv_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input logic                clk,
  input logic                rst_n,
  input rv_pkg::word_t       pc,
  input rv_pkg::core_state_t state,
  input logic                halted
);

  // pc always on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  // halted core holds pc and state
  halt_frozen: assert property (@(posedge clk)
    (halted && rst_n) |=> (!rst_n || (pc == $past(pc) && state == $past(state))))
    else $error("pc or state moved while halted");

  // reset vector loaded by a reset edge
  reset_vector: assert property (@(posedge clk)
    !rst_n |=> pc == RESET_PC)
    else $error("pc not at reset vector after reset");

endmodule

// attach to every pc_unit
bind pc_unit core_props #(
  .RESET_PC(RESET_PC)
) core_props_inst (
  .clk   (clk),
  .rst_n (rst_n),
  .pc    (pc),
  .state (state),
  .halted(halted)
);

// ==== test/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
  import rv_pkg::*;

  localparam word_t BASE_PC = 32'h8000_0000;
  localparam word_t NOP_INST = 32'h0000_0013;
  localparam word_t EBREAK_INST = 32'h0010_0073;
  localparam int PROG_DEPTH = 64;
  localparam int MAX_CYCLES = 2000;

  logic      clk;
  logic      rst_n;
  word_t     inst;
  word_t     pc;
  logic      halted;
  logic      rd_wen;
  reg_addr_t rd_addr;
  word_t     rd_data;

  // program seen by the core, and the one staged for the next reset
  word_t prog [0:PROG_DEPTH-1];
  word_t staged [0:PROG_DEPTH-1];
  // reference model state
  word_t mregs [0:31];
  word_t mpc;
  logic  mhalted;

  int    errors;
  int    tests_run;
  int    tests_failed;
  int    cycles;
  logic [31:0] lfsr;

  rv_core_top rv_core_top_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .inst   (inst),
    .pc     (pc),
    .halted (halted),
    .rd_wen (rd_wen),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  always #2 clk = ~clk;

  // outside the loaded program reads as a nop
  function automatic word_t fetch(word_t addr);
    word_t off;
    off = addr - BASE_PC;
    if (off[31:8] == 24'h0) begin
      return prog[off[7:2]];
    end
    return NOP_INST;
  endfunction

  // small assemblers for the supported formats
  function automatic word_t enc_i(int imm, reg_addr_t rs1, logic [2:0] f3, reg_addr_t rd,
                                  opcode_t op);
    logic [31:0] v;
    v = imm;
    return {v[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_jal(reg_addr_t rd, int off);
    logic [31:0] v;
    v = off;
    return {v[20], v[10:1], v[11], v[19:12], rd, OP_JAL};
  endfunction

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      if (lfsr[0]) begin
        lfsr = (lfsr >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr = lfsr >> 1;
      end
    end
    return r;
  endfunction

  task automatic compare_word(string name, word_t got, word_t exp);
    assert (got === exp) else begin
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    assert (got === exp) else begin
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // drive the instruction for the current pc
  always @(negedge clk) begin
    inst <= fetch(pc);
  end

  // reference model, checks every retire against the isa rules
  always @(posedge clk) begin : ref_model
    word_t     ins;
    word_t     wdata;
    word_t     nxt;
    word_t     sum;
    word_t     simm;
    reg_addr_t rd;
    logic      wen;
    if (!rst_n) begin
      compare_bit("rd_wen", rd_wen, 1'b0);
      mpc = BASE_PC;
      mhalted = 1'b0;
    end else begin
      compare_word("pc", pc, mpc);
      compare_bit("halted", halted, mhalted);
      ins = fetch(mpc);
      rd = ins[11:7];
      simm = {{20{ins[31]}}, ins[31:20]};
      wen = 1'b0;
      wdata = '0;
      nxt = mhalted ? mpc : mpc + INST_BYTES;
      if (!mhalted) begin
        case (ins[6:0])
          OP_IMM: begin
            if (ins[14:12] == 3'b000) begin
              wen = 1'b1;
              wdata = mregs[ins[19:15]] + simm;
            end
          end
          OP_LUI: begin
            wen = 1'b1;
            wdata = {ins[31:12], 12'h000};
          end
          OP_AUIPC: begin
            wen = 1'b1;
            wdata = mpc + {ins[31:12], 12'h000};
          end
          OP_JAL: begin
            wen = 1'b1;
            wdata = mpc + 32'd4;
            nxt = mpc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
          end
          OP_JALR: begin
            wen = 1'b1;
            wdata = mpc + 32'd4;
            sum = mregs[ins[19:15]] + simm;
            nxt = {sum[31:1], 1'b0};
          end
          OP_SYSTEM: begin
            if (ins == EBREAK_INST) begin
              mhalted = 1'b1;
              nxt = mpc;
            end
          end
          default: begin
          end
        endcase
      end
      compare_bit("rd_wen", rd_wen, wen);
      if (wen) begin
        compare_word("rd_addr", {27'h0, rd_addr}, {27'h0, rd});
        compare_word("rd_data", rd_data, wdata);
        if (rd != 5'd0) begin
          mregs[rd] = wdata;
        end
      end
      mpc = nxt;
    end
  end

  // hard stop on a hung run
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped: cycle limit of %0d reached", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic clear_program();
    for (int i = 0; i < PROG_DEPTH; i++) begin
      staged[i] = NOP_INST;
    end
  endtask

  // program swaps while reset is low
  task automatic reset_core();
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < PROG_DEPTH; i++) begin
      prog[i] = staged[i];
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic run_cycles(int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic report_test(string name, int errors_before);
    tests_run++;
    if (errors != errors_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    clear_program();
    reset_core();
    compare_word("pc", pc, BASE_PC);
    compare_bit("halted", halted, 1'b0);
    run_cycles(2);
    report_test("reset", e0);
  endtask

  task automatic test_addi_chain();
    int e0;
    e0 = errors;
    clear_program();
    staged[0] = enc_i(5, 5'd0, 3'b000, 5'd1, OP_IMM);
    staged[1] = enc_i(-3, 5'd0, 3'b000, 5'd2, OP_IMM);
    staged[2] = enc_i(100, 5'd1, 3'b000, 5'd1, OP_IMM);
    staged[3] = enc_i(-2000, 5'd2, 3'b000, 5'd2, OP_IMM);
    staged[4] = enc_i(7, 5'd0, 3'b000, 5'd0, OP_IMM);
    staged[5] = enc_i(1, 5'd0, 3'b000, 5'd3, OP_IMM);
    reset_core();
    run_cycles(6);
    compare_word("x1", mregs[1], 32'd105);
    compare_word("x2", mregs[2], 32'hffff_f82d);
    compare_word("x3", mregs[3], 32'd1);
    compare_word("pc", pc, BASE_PC + 32'd24);
    report_test("addi_chain", e0);
  endtask

  task automatic test_upper_imm();
    int e0;
    e0 = errors;
    clear_program();
    staged[0] = enc_u(20'h12345, 5'd5, OP_LUI);
    staged[1] = enc_u(20'hfffff, 5'd6, OP_AUIPC);
    reset_core();
    run_cycles(2);
    compare_word("x5", mregs[5], 32'h1234_5000);
    compare_word("x6", mregs[6], 32'h7fff_f004);
    report_test("lui_auipc", e0);
  endtask

  task automatic test_jumps();
    int e0;
    e0 = errors;
    clear_program();
    staged[0] = enc_jal(5'd1, 8);
    staged[1] = enc_i(1, 5'd0, 3'b000, 5'd9, OP_IMM);
    staged[2] = enc_u(20'h80000, 5'd2, OP_LUI);
    // odd sum, lands on index 8
    staged[3] = enc_i(33, 5'd2, 3'b000, 5'd3, OP_JALR);
    staged[4] = enc_i(2, 5'd0, 3'b000, 5'd9, OP_IMM);
    staged[8] = enc_i(7, 5'd0, 3'b000, 5'd4, OP_IMM);
    reset_core();
    run_cycles(4);
    compare_word("x1", mregs[1], BASE_PC + 32'd4);
    compare_word("x3", mregs[3], BASE_PC + 32'd16);
    compare_word("x4", mregs[4], 32'd7);
    compare_word("pc", pc, BASE_PC + 32'd36);
    report_test("jumps", e0);
  endtask

  task automatic test_halt();
    int e0;
    e0 = errors;
    clear_program();
    staged[0] = 32'h0000_007f;
    // slti, funct3 010
    staged[1] = enc_i(5, 5'd0, 3'b010, 5'd7, OP_IMM);
    staged[2] = EBREAK_INST;
    staged[3] = enc_i(9, 5'd0, 3'b000, 5'd8, OP_IMM);
    reset_core();
    run_cycles(3);
    compare_bit("halted", halted, 1'b1);
    // halted core now fetches a jal, both write and jump must stay masked
    prog[2] = enc_jal(5'd10, 8);
    for (int i = 0; i < 10; i++) begin
      run_cycles(1);
      compare_word("pc", pc, BASE_PC + 32'd8);
      compare_bit("rd_wen", rd_wen, 1'b0);
      compare_bit("halted", halted, 1'b1);
    end
    reset_core();
    compare_bit("halted", halted, 1'b0);
    run_cycles(2);
    compare_word("pc", pc, BASE_PC + 32'd8);
    report_test("halt", e0);
  endtask

  task automatic test_random_addi();
    int e0;
    logic [31:0] r_imm;
    logic [31:0] r_rs1;
    logic [31:0] r_rd;
    e0 = errors;
    clear_program();
    // seed x1..x7 so every source is defined
    for (int i = 1; i < 8; i++) begin
      staged[i-1] = enc_i(i * 11, 5'd0, 3'b000, i[4:0], OP_IMM);
    end
    for (int i = 7; i < 39; i++) begin
      // draw order fixed: immediate, rs1, rd
      r_imm = rand_bits(12);
      r_rs1 = rand_bits(3);
      r_rd = rand_bits(3);
      staged[i] = enc_i(int'(r_imm), {2'b00, r_rs1[2:0]},
                        3'b000, {2'b00, r_rd[2:0]}, OP_IMM);
    end
    reset_core();
    run_cycles(39);
    compare_word("pc", pc, BASE_PC + 32'd156);
    report_test("random_addi", e0);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    inst = NOP_INST;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycles = 0;
    lfsr = 32'h5ed6_c6e4;
    mpc = BASE_PC;
    mhalted = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    clear_program();
    test_reset();
    test_addi_chain();
    test_upper_imm();
    test_jumps();
    test_halt();
    test_random_addi();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
